// ==== build.f ====
+incdir+include
src/mulDivPkg.sv
src/seqDivider.sv
src/seqMultiplier.sv
src/resultCollect.sv
src/axiLiteMulDivRegs.sv
src/mulDivTop.sv
sim/mulDivTb.sv

// ==== Bender.yml ====
package:
  name: mulDiv

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/mulDivPkg.sv
      - src/seqDivider.sv
      - src/seqMultiplier.sv
      - src/resultCollect.sv
      - src/axiLiteMulDivRegs.sv
      - src/mulDivTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/mulDivTb.sv

// ==== sim/mulDivTb.sv ====
// Testbench of the multiply/divide coprocessor
// Directed AXI4-Lite tests against arithmetic reference models
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_defines.svh"

module mulDivTb;

	localparam int TIMEOUT = 200;
	localparam int MAX_POLLS = 100;
	localparam logic [63:0] MIN_NEG = 64'h8000_0000_0000_0000;

	logic clk;
	logic rst;
	mulDivPkg::axiLiteReqS axiReq;
	mulDivPkg::axiLiteRespS axiResp;
	integer seed;

	mulDivTop uut (
		.clk(clk),
		.rst(rst),
		.axiReq(axiReq),
		.axiResp(axiResp)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// ========================================================================
	// Failure reporting and compare tasks
	// ========================================================================

	task automatic failValue(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "Stopped at the first failed check");
	endtask

	task automatic failTimeout(input string what);
		$display("Timed out at %0t waiting for %s", $time, what);
		$display("Test failures found");
		$fatal(1, "Stopped on a timeout");
	endtask

	task automatic checkResult(input logic [63:0] got0, input logic [63:0] got1,
		input logic [63:0] exp0, input logic [63:0] exp1, input string what);
		if (got0 !== exp0 || got1 !== exp1) begin
			failValue($sformatf("%s: got %h / %h, expected %h / %h",
				what, got0, got1, exp0, exp1));
		end
	endtask

	task automatic checkStatus(input mulDivPkg::mdStatusS got,
		input mulDivPkg::mdStatusS exp, input string what);
		if (got !== exp) begin
			failValue($sformatf("%s: busy/done/dbz/op %b/%b/%b/%0d, expected %b/%b/%b/%0d",
				what, got.busy, got.done, got.divByZero, got.lastOp,
				exp.busy, exp.done, exp.divByZero, exp.lastOp));
		end
	endtask

	task automatic checkResp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp) begin
			failValue($sformatf("%s: response %0d, expected %0d", what, got, exp));
		end
	endtask

	task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			failValue($sformatf("%s: data %h, expected %h", what, got, exp));
		end
	endtask

	// ========================================================================
	// Reference models returning {res1, res0}
	// ========================================================================

	function automatic logic [127:0] mulModel(input mulDivPkg::mdOpE op,
		input logic [63:0] a, input logic [63:0] b);
		logic signed [127:0] sa;
		logic signed [127:0] sb;
		if (op == mulDivPkg::opMul) begin
			sa = {{64{a[63]}}, a};
			sb = {{64{b[63]}}, b};
		end else begin
			sa = {64'b0, a};
			sb = {64'b0, b};
		end
		return sa * sb;
	endfunction

	function automatic logic [127:0] divModel(input mulDivPkg::mdOpE op,
		input logic [63:0] a, input logic [63:0] b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		sa = a;
		sb = b;
		// Zero divisor gives all ones and the dividend as remainder
		if (b == 64'd0) begin
			return {a, {64{1'b1}}};
		end
		if (op == mulDivPkg::opDivU) begin
			return {a % b, a / b};
		end
		// Overflow case wraps back to the most negative value
		if (a == MIN_NEG && b == {64{1'b1}}) begin
			return {64'd0, MIN_NEG};
		end
		// Truncating division with the remainder in the dividend sign
		return {sa % sb, sa / sb};
	endfunction

	// ========================================================================
	// AXI4-Lite master
	// ========================================================================

	// hold keeps bready low for that many cycles once bvalid is up
	task automatic axiWrite(input logic [`MD_AXI_AW-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int hold, output logic [1:0] resp);
		int cnt;
		@(posedge clk);
		axiReq.awaddr <= addr;
		axiReq.awvalid <= 1'b1;
		axiReq.wdata <= data;
		axiReq.wstrb <= strb;
		axiReq.wvalid <= 1'b1;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
			if (cnt > TIMEOUT) begin
				failTimeout("awready and wready");
			end
		end while (!(axiResp.awready && axiResp.wready));
		// Handshake edge
		@(posedge clk);
		axiReq.awvalid <= 1'b0;
		axiReq.wvalid <= 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
			if (cnt > TIMEOUT) begin
				failTimeout("bvalid");
			end
		end while (!axiResp.bvalid);
		resp = axiResp.bresp;
		// Response has to stay put while the master stalls
		repeat (hold) begin
			@(negedge clk);
			if (!axiResp.bvalid) begin
				failValue("bvalid dropped before bready");
			end
			checkResp(axiResp.bresp, resp, "bresp under back-pressure");
		end
		@(posedge clk);
		axiReq.bready <= 1'b1;
		@(posedge clk);
		axiReq.bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [`MD_AXI_AW-1:0] addr, input int hold,
		output logic [31:0] data, output logic [1:0] resp);
		int cnt;
		@(posedge clk);
		axiReq.araddr <= addr;
		axiReq.arvalid <= 1'b1;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
			if (cnt > TIMEOUT) begin
				failTimeout("arready");
			end
		end while (!axiResp.arready);
		@(posedge clk);
		axiReq.arvalid <= 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
			if (cnt > TIMEOUT) begin
				failTimeout("rvalid");
			end
		end while (!axiResp.rvalid);
		data = axiResp.rdata;
		resp = axiResp.rresp;
		repeat (hold) begin
			@(negedge clk);
			if (!axiResp.rvalid) begin
				failValue("rvalid dropped before rready");
			end
			checkWord(axiResp.rdata, data, "rdata under back-pressure");
			checkResp(axiResp.rresp, resp, "rresp under back-pressure");
		end
		@(posedge clk);
		axiReq.rready <= 1'b1;
		@(posedge clk);
		axiReq.rready <= 1'b0;
	endtask

	// ========================================================================
	// Register level helpers
	// ========================================================================

	task automatic writeReg(input logic [`MD_AXI_AW-1:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axiWrite(addr, data, 4'hF, 0, resp);
		checkResp(resp, `MD_AXI_OKAY, $sformatf("write to %h", addr));
	endtask

	// Low word at addrLo and high word four bytes above
	task automatic readPair(input logic [`MD_AXI_AW-1:0] addrLo, output logic [63:0] value);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [1:0] resp;
		axiRead(addrLo, 0, lo, resp);
		checkResp(resp, `MD_AXI_OKAY, $sformatf("read of %h", addrLo));
		axiRead(addrLo + 8'h04, 0, hi, resp);
		checkResp(resp, `MD_AXI_OKAY, $sformatf("read of %h", addrLo + 8'h04));
		value = {hi, lo};
	endtask

	task automatic writeOperands(input logic [63:0] a, input logic [63:0] b);
		writeReg(`MD_REG_ALO, a[31:0]);
		writeReg(`MD_REG_AHI, a[63:32]);
		writeReg(`MD_REG_BLO, b[31:0]);
		writeReg(`MD_REG_BHI, b[63:32]);
	endtask

	task automatic issueCmd(input mulDivPkg::mdOpE op, input logic [1:0] expResp);
		logic [1:0] resp;
		axiWrite(`MD_REG_CMD, {30'd0, op}, 4'hF, 0, resp);
		checkResp(resp, expResp, "command write");
	endtask

	// Status word has busy, done and divByZero at 2:0 and lastOp at 5:4
	task automatic readStatus(output mulDivPkg::mdStatusS st);
		logic [31:0] w;
		logic [1:0] resp;
		axiRead(`MD_REG_STATUS, 0, w, resp);
		checkResp(resp, `MD_AXI_OKAY, "status read");
		st.busy = w[0];
		st.done = w[1];
		st.divByZero = w[2];
		st.lastOp = mulDivPkg::mdOpE'(w[5:4]);
	endtask

	task automatic waitDone(output mulDivPkg::mdStatusS st);
		int polls;
		polls = 0;
		do begin
			readStatus(st);
			polls++;
			if (polls > MAX_POLLS) begin
				failTimeout("the done status bit");
			end
		end while (!st.done);
	endtask

	task automatic runOp(input mulDivPkg::mdOpE op, input logic [63:0] a, input logic [63:0] b,
		output mulDivPkg::mdStatusS st, output logic [63:0] r0, output logic [63:0] r1);
		writeOperands(a, b);
		issueCmd(op, `MD_AXI_OKAY);
		waitDone(st);
		readPair(`MD_REG_R0LO, r0);
		readPair(`MD_REG_R1LO, r1);
	endtask

	function automatic logic isDivOp(input mulDivPkg::mdOpE op);
		return op == mulDivPkg::opDiv || op == mulDivPkg::opDivU;
	endfunction

	// One command end to end against the models
	task automatic verifyOp(input mulDivPkg::mdOpE op, input logic [63:0] a,
		input logic [63:0] b, input string what);
		logic [127:0] exp;
		logic [63:0] r0;
		logic [63:0] r1;
		mulDivPkg::mdStatusS st;
		mulDivPkg::mdStatusS expSt;
		exp = isDivOp(op) ? divModel(op, a, b) : mulModel(op, a, b);
		runOp(op, a, b, st, r0, r1);
		expSt.busy = 1'b0;
		expSt.done = 1'b1;
		expSt.divByZero = isDivOp(op) && b == 64'd0;
		expSt.lastOp = op;
		checkStatus(st, expSt, what);
		checkResult(r0, r1, exp[63:0], exp[127:64], what);
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic testResetState();
		mulDivPkg::mdStatusS st;
		@(negedge clk);
		if (axiResp.awready || axiResp.wready || axiResp.bvalid ||
			axiResp.arready || axiResp.rvalid) begin
			failValue("AXI handshake output high after reset");
		end
		readStatus(st);
		checkStatus(st, '0, "status after reset");
	endtask

	task automatic testUnsigned();
		logic [63:0] a;
		logic [63:0] b;
		verifyOp(mulDivPkg::opMulU, 64'd7, 64'd3, "mulu small");
		verifyOp(mulDivPkg::opMulU, '1, '1, "mulu all ones");
		verifyOp(mulDivPkg::opDivU, 64'd100, 64'd7, "divu small");
		verifyOp(mulDivPkg::opDivU, '1, 64'd1, "divu by one");
		verifyOp(mulDivPkg::opDivU, 64'd5, 64'd10, "divu smaller dividend");
		for (int i = 0; i < 4; i++) begin
			a = {$random(seed), $random(seed)};
			b = {$random(seed), $random(seed)};
			verifyOp(mulDivPkg::opMulU, a, b, $sformatf("mulu random %0d", i));
			// Narrow divisor gives a wide quotient
			verifyOp(mulDivPkg::opDivU, a, b >> (i * 16), $sformatf("divu random %0d", i));
		end
	endtask

	task automatic testSigned();
		logic [63:0] a;
		logic [63:0] b;
		verifyOp(mulDivPkg::opMul, 64'd7, 64'd3, "mul ++");
		verifyOp(mulDivPkg::opMul, -64'd7, 64'd3, "mul -+");
		verifyOp(mulDivPkg::opMul, 64'd7, -64'd3, "mul +-");
		verifyOp(mulDivPkg::opMul, -64'd7, -64'd3, "mul --");
		verifyOp(mulDivPkg::opDiv, 64'd7, 64'd3, "div ++");
		verifyOp(mulDivPkg::opDiv, -64'd7, 64'd3, "div -+");
		verifyOp(mulDivPkg::opDiv, 64'd7, -64'd3, "div +-");
		verifyOp(mulDivPkg::opDiv, -64'd7, -64'd3, "div --");
		verifyOp(mulDivPkg::opDiv, MIN_NEG, '1, "div overflow");
		verifyOp(mulDivPkg::opMul, MIN_NEG, '1, "mul most negative by -1");
		for (int i = 0; i < 4; i++) begin
			a = {$random(seed), $random(seed)};
			b = {{16{1'b0}}, $random(seed), 16'h0};
			// Sign combinations cycled on random magnitudes
			a[63] = i[0];
			b = i[1] ? -b : b;
			verifyOp(mulDivPkg::opMul, a, b, $sformatf("mul random %0d", i));
			verifyOp(mulDivPkg::opDiv, a, b, $sformatf("div random %0d", i));
		end
	endtask

	task automatic testDivByZero();
		verifyOp(mulDivPkg::opDivU, 64'h0123_4567_89AB_CDEF, 64'd0, "divu by zero");
		verifyOp(mulDivPkg::opDiv, -64'd12345, 64'd0, "div by zero negative");
		// Flag drops with the next good command
		verifyOp(mulDivPkg::opDiv, -64'd12345, 64'd10, "div after zero");
	endtask

	task automatic testBusyRefusal();
		mulDivPkg::mdStatusS st;
		mulDivPkg::mdStatusS expSt;
		logic [127:0] exp;
		logic [63:0] r0;
		logic [63:0] r1;
		exp = divModel(mulDivPkg::opDivU, 64'hFEDC_BA98_7654_3210, 64'd1000);
		writeOperands(64'hFEDC_BA98_7654_3210, 64'd1000);
		issueCmd(mulDivPkg::opDivU, `MD_AXI_OKAY);
		issueCmd(mulDivPkg::opMul, `MD_AXI_SLVERR);
		readStatus(st);
		expSt = '0;
		expSt.busy = 1'b1;
		expSt.lastOp = mulDivPkg::opDivU;
		checkStatus(st, expSt, "status while busy");
		waitDone(st);
		expSt.busy = 1'b0;
		expSt.done = 1'b1;
		checkStatus(st, expSt, "status after refused command");
		readPair(`MD_REG_R0LO, r0);
		readPair(`MD_REG_R1LO, r1);
		checkResult(r0, r1, exp[63:0], exp[127:64], "result after refused command");
	endtask

	task automatic testErrorsAndReadback();
		logic [63:0] a;
		logic [63:0] b;
		logic [31:0] data;
		logic [1:0] resp;
		writeOperands(64'hA5A5_0001_5A5A_0002, 64'h1234_5678_9ABC_DEF0);
		axiWrite(`MD_REG_ALO, 32'hDEAD_BEEF, 4'b0011, 0, resp);
		checkResp(resp, `MD_AXI_SLVERR, "partial strobe write");
		axiWrite(8'h28, 32'h1111_2222, 4'hF, 0, resp);
		checkResp(resp, `MD_AXI_SLVERR, "unmapped write");
		axiWrite(`MD_REG_STATUS, 32'hFFFF_FFFF, 4'hF, 0, resp);
		checkResp(resp, `MD_AXI_SLVERR, "status write");
		readPair(`MD_REG_ALO, a);
		readPair(`MD_REG_BLO, b);
		checkResult(a, b, 64'hA5A5_0001_5A5A_0002, 64'h1234_5678_9ABC_DEF0, "operand readback");
		axiRead(8'h2C, 0, data, resp);
		checkResp(resp, `MD_AXI_SLVERR, "unmapped read");
		checkWord(data, 32'd0, "unmapped read data");
	endtask

	task automatic testBackPressure();
		logic [31:0] data;
		logic [1:0] resp;
		logic [127:0] exp;
		logic [63:0] r0;
		logic [63:0] r1;
		mulDivPkg::mdStatusS st;
		mulDivPkg::mdStatusS expSt;
		axiWrite(`MD_REG_BLO, 32'hC0DE_0042, 4'hF, 6, resp);
		checkResp(resp, `MD_AXI_OKAY, "held write");
		axiRead(`MD_REG_BLO, 6, data, resp);
		checkResp(resp, `MD_AXI_OKAY, "held read");
		checkWord(data, 32'hC0DE_0042, "held read data");
		axiWrite(8'h3C, 32'h0, 4'hF, 5, resp);
		checkResp(resp, `MD_AXI_SLVERR, "held error write");
		axiRead(8'h30, 5, data, resp);
		checkResp(resp, `MD_AXI_SLVERR, "held error read");
		checkWord(data, 32'd0, "held error read data");
		// Status read held past the end of a multiply keeps its busy snapshot
		exp = mulModel(mulDivPkg::opMulU, 64'h0000_0001_2345_6789, 64'h0000_0000_9876_5432);
		writeOperands(64'h0000_0001_2345_6789, 64'h0000_0000_9876_5432);
		issueCmd(mulDivPkg::opMulU, `MD_AXI_OKAY);
		axiRead(`MD_REG_STATUS, 2 * `MD_ITER, data, resp);
		checkResp(resp, `MD_AXI_OKAY, "held status read");
		checkWord(data, {26'd0, mulDivPkg::opMulU, 4'b0001}, "held status read data");
		waitDone(st);
		expSt = '0;
		expSt.done = 1'b1;
		expSt.lastOp = mulDivPkg::opMulU;
		checkStatus(st, expSt, "status after held read");
		readPair(`MD_REG_R0LO, r0);
		readPair(`MD_REG_R1LO, r1);
		checkResult(r0, r1, exp[63:0], exp[127:64], "result after held read");
	endtask

	// ========================================================================
	// Sequence
	// ========================================================================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		axiReq = '0;
		seed = 37;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		testResetState();
		testUnsigned();
		testSigned();
		testDivByZero();
		testBusyRefusal();
		testErrorsAndReadback();
		testBackPressure();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/mulDivTop.sv ====
// Multiply/divide coprocessor top level
// AXI4-Lite register block feeding a divider and a multiplier
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_defines.svh"

module mulDivTop (
	input wire logic clk,
	input wire logic rst,
	input wire mulDivPkg::axiLiteReqS axiReq,
	output mulDivPkg::axiLiteRespS axiResp
);

	// Command path
	mulDivPkg::mdReqS cmd;
	logic divStart;
	logic mulStart;
	logic cmdIssue;

	// Result path
	mulDivPkg::unitResS divRes;
	mulDivPkg::unitResS mulRes;
	logic [`MD_XLEN-1:0] res0;
	logic [`MD_XLEN-1:0] res1;
	mulDivPkg::mdStatusS status;

	axiLiteMulDivRegs regs (
		.clk(clk),
		.rst(rst),
		.axiReq(axiReq),
		.axiResp(axiResp),
		.cmd(cmd),
		.divStart(divStart),
		.mulStart(mulStart),
		.cmdIssue(cmdIssue),
		.res0(res0),
		.res1(res1),
		.status(status)
	);

	seqDivider divider (
		.clk(clk),
		.rst(rst),
		.start(divStart),
		.req(cmd),
		.res(divRes)
	);

	seqMultiplier multiplier (
		.clk(clk),
		.rst(rst),
		.start(mulStart),
		.req(cmd),
		.res(mulRes)
	);

	// Opcode for lastOp rides with the command
	resultCollect collect (
		.clk(clk),
		.rst(rst),
		.cmdIssue(cmdIssue),
		.cmdOp(cmd.op),
		.divRes(divRes),
		.mulRes(mulRes),
		.res0(res0),
		.res1(res1),
		.status(status)
	);

endmodule

`default_nettype wire

// ==== src/axiLiteMulDivRegs.sv ====
// AXI4-Lite register block of the coprocessor
// Operand registers, command decode with busy refusal, result and status reads
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_defines.svh"

module axiLiteMulDivRegs (
	input wire logic clk,
	input wire logic rst,
	input wire mulDivPkg::axiLiteReqS axiReq,
	output mulDivPkg::axiLiteRespS axiResp,
	output mulDivPkg::mdReqS cmd,
	output logic divStart,
	output logic mulStart,
	output logic cmdIssue,
	input wire logic [`MD_XLEN-1:0] res0,
	input wire logic [`MD_XLEN-1:0] res1,
	input wire mulDivPkg::mdStatusS status
);

	// Write: accept, decode, respond
	typedef enum logic [1:0] {
		wrIdle,
		wrAck,
		wrExec,
		wrResp
	} wrStateE;

	typedef enum logic [1:0] {
		rdIdle,
		rdAck,
		rdResp
	} rdStateE;

	wrStateE wrState;
	rdStateE rdState;

	// Channel outputs
	logic awReady;
	logic bValid;
	logic [1:0] bResp;
	logic arReady;
	logic rValid;
	logic [1:0] rResp;
	logic [`MD_AXI_DW-1:0] rData;

	// Captured request
	logic [`MD_AXI_AW-1:0] wrAddr;
	logic [`MD_AXI_DW-1:0] wrData;
	logic [`MD_AXI_DW/8-1:0] wrStrb;
	logic [`MD_AXI_AW-1:0] rdAddr;

	logic [`MD_XLEN-1:0] opA;
	logic [`MD_XLEN-1:0] opB;
	mulDivPkg::mdOpE cmdOp;

	logic wrStartOk;
	logic rdStartOk;
	logic wrIsCmd;
	logic wrMapped;
	logic wrOk;
	mulDivPkg::mdOpE newOp;
	logic rdMapped;
	logic [`MD_AXI_DW-1:0] rdMux;

	// One transaction at a time, a write wins over a read
	always_comb begin
		wrStartOk = wrState == wrIdle && rdState == rdIdle &&
			axiReq.awvalid && axiReq.wvalid;
		rdStartOk = rdState == rdIdle && wrState == wrIdle && axiReq.arvalid &&
			!(axiReq.awvalid && axiReq.wvalid);
	end

	// ========================================================================
	// Write decode
	// ========================================================================

	always_comb begin
		newOp = mulDivPkg::mdOpE'(wrData[1:0]);
		wrIsCmd = wrAddr == `MD_REG_CMD;
		// Status and results are read only
		wrMapped = wrIsCmd ||
			wrAddr inside {`MD_REG_ALO, `MD_REG_AHI, `MD_REG_BLO, `MD_REG_BHI};
		// Full strobe only, no command while a unit runs
		wrOk = wrMapped && wrStrb == '1 && !(wrIsCmd && status.busy);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrState <= wrIdle;
			awReady <= 1'b0;
			bValid <= 1'b0;
			divStart <= 1'b0;
			mulStart <= 1'b0;
			cmdIssue <= 1'b0;
			cmdOp <= mulDivPkg::opMul;
		end else begin
			// Pulses
			divStart <= 1'b0;
			mulStart <= 1'b0;
			cmdIssue <= 1'b0;
			case (wrState)
				wrIdle: begin
					if (wrStartOk) begin
						awReady <= 1'b1;
						wrState <= wrAck;
					end
				end
				wrAck: begin
					awReady <= 1'b0;
					wrState <= wrExec;
				end
				wrExec: begin
					bValid <= 1'b1;
					wrState <= wrResp;
					if (wrOk && wrIsCmd) begin
						cmdOp <= newOp;
						cmdIssue <= 1'b1;
						// Unit choice by opcode
						divStart <= newOp inside {mulDivPkg::opDiv, mulDivPkg::opDivU};
						mulStart <= newOp inside {mulDivPkg::opMul, mulDivPkg::opMulU};
					end
				end
				default: begin
					// Hold the response until the master takes it
					if (axiReq.bready) begin
						bValid <= 1'b0;
						wrState <= wrIdle;
					end
				end
			endcase
		end
	end

	// Captured address, data and operand halves
	always_ff @(posedge clk) begin
		if (wrStartOk) begin
			wrAddr <= axiReq.awaddr;
			wrData <= axiReq.wdata;
			wrStrb <= axiReq.wstrb;
		end
		if (wrState == wrExec) begin
			bResp <= wrOk ? `MD_AXI_OKAY : `MD_AXI_SLVERR;
			if (wrOk) begin
				case (wrAddr)
					`MD_REG_ALO: opA[`MD_AXI_DW-1:0] <= wrData;
					`MD_REG_AHI: opA[`MD_XLEN-1:`MD_AXI_DW] <= wrData;
					`MD_REG_BLO: opB[`MD_AXI_DW-1:0] <= wrData;
					`MD_REG_BHI: opB[`MD_XLEN-1:`MD_AXI_DW] <= wrData;
					default: begin
					end
				endcase
			end
		end
	end

	// ========================================================================
	// Read path
	// ========================================================================

	always_comb begin
		rdMapped = 1'b1;
		rdMux = '0;
		case (rdAddr)
			`MD_REG_ALO: rdMux = opA[`MD_AXI_DW-1:0];
			`MD_REG_AHI: rdMux = opA[`MD_XLEN-1:`MD_AXI_DW];
			`MD_REG_BLO: rdMux = opB[`MD_AXI_DW-1:0];
			`MD_REG_BHI: rdMux = opB[`MD_XLEN-1:`MD_AXI_DW];
			`MD_REG_CMD: rdMux = {{(`MD_AXI_DW-2){1'b0}}, cmdOp};
			`MD_REG_STATUS: begin
				// lastOp at 5:4, bit 3 reserved
				rdMux = {{(`MD_AXI_DW-6){1'b0}}, status.lastOp, 1'b0,
					status.divByZero, status.done, status.busy};
			end
			`MD_REG_R0LO: rdMux = res0[`MD_AXI_DW-1:0];
			`MD_REG_R0HI: rdMux = res0[`MD_XLEN-1:`MD_AXI_DW];
			`MD_REG_R1LO: rdMux = res1[`MD_AXI_DW-1:0];
			`MD_REG_R1HI: rdMux = res1[`MD_XLEN-1:`MD_AXI_DW];
			default: rdMapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rdState <= rdIdle;
			arReady <= 1'b0;
			rValid <= 1'b0;
		end else begin
			case (rdState)
				rdIdle: begin
					if (rdStartOk) begin
						arReady <= 1'b1;
						rdState <= rdAck;
					end
				end
				rdAck: begin
					arReady <= 1'b0;
					rValid <= 1'b1;
					rdState <= rdResp;
				end
				default: begin
					if (axiReq.rready) begin
						rValid <= 1'b0;
						rdState <= rdIdle;
					end
				end
			endcase
		end
	end

	// Read data frozen while rvalid waits
	always_ff @(posedge clk) begin
		if (rdStartOk) begin
			rdAddr <= axiReq.araddr;
		end
		if (rdState == rdAck) begin
			rData <= rdMux;
			rResp <= rdMapped ? `MD_AXI_OKAY : `MD_AXI_SLVERR;
		end
	end

	always_comb begin
		axiResp.awready = awReady;
		axiResp.wready = awReady;
		axiResp.bresp = bResp;
		axiResp.bvalid = bValid;
		axiResp.arready = arReady;
		axiResp.rdata = rData;
		axiResp.rresp = rResp;
		axiResp.rvalid = rValid;
		// Operands go out with the start pulse
		cmd.op = cmdOp;
		cmd.a = opA;
		cmd.b = opB;
	end

endmodule

`default_nettype wire

// ==== src/resultCollect.sv ====
// Result collector, holds the finishing unit's result
// Keeps busy, done, divide-by-zero and last opcode for the status word
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_defines.svh"

module resultCollect (
	input wire logic clk,
	input wire logic rst,
	input wire logic cmdIssue,
	input wire mulDivPkg::mdOpE cmdOp,
	input wire mulDivPkg::unitResS divRes,
	input wire mulDivPkg::unitResS mulRes,
	output logic [`MD_XLEN-1:0] res0,
	output logic [`MD_XLEN-1:0] res1,
	output mulDivPkg::mdStatusS status
);

	// Only one unit runs at a time, so at most one done pulses
	mulDivPkg::unitResS finRes;
	logic finDone;

	always_comb begin
		finDone = divRes.done || mulRes.done;
		finRes = divRes.done ? divRes : mulRes;
	end

	// Status flags
	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '0;
		end else if (cmdIssue) begin
			// New command clears the previous outcome
			status.busy <= 1'b1;
			status.done <= 1'b0;
			status.divByZero <= 1'b0;
			status.lastOp <= cmdOp;
		end else if (finDone) begin
			status.busy <= 1'b0;
			status.done <= 1'b1;
			status.divByZero <= finRes.divByZero;
		end
	end

	// Held until the next command finishes
	always_ff @(posedge clk) begin
		if (finDone) begin
			res0 <= finRes.res0;
			res1 <= finRes.res1;
		end
	end

endmodule

`default_nettype wire

// ==== src/seqMultiplier.sv ====
// Sequential shift-add multiplier, one multiplier bit per cycle
// 128-bit product, sign restored at the end for signed operands
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_defines.svh"

module seqMultiplier (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire mulDivPkg::mdReqS req,
	output mulDivPkg::unitResS res
);

	mulDivPkg::unitStateE state;
	logic [`MD_CNT_W-1:0] cnt;

	logic [`MD_XLEN-1:0] mcand;
	// High half accumulates, low half starts as the multiplier
	logic [2*`MD_XLEN-1:0] prod;
	logic [2*`MD_XLEN-1:0] product;
	logic isSigned;
	logic neg;

	logic [`MD_XLEN-1:0] addend;
	logic [`MD_XLEN:0] sum;

	always_comb begin
		addend = prod[0] ? mcand : {`MD_XLEN{1'b0}};
		sum = {1'b0, prod[2*`MD_XLEN-1:`MD_XLEN]} + {1'b0, addend};
	end

	// Same sequencing as the divider
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mulDivPkg::stIdle;
			cnt <= '0;
		end else begin
			case (state)
				mulDivPkg::stIdle: begin
					if (start) begin
						state <= mulDivPkg::stLoad;
					end
				end
				mulDivPkg::stLoad: begin
					state <= mulDivPkg::stRun;
					cnt <= `MD_CNT_W'(`MD_ITER);
				end
				mulDivPkg::stRun: begin
					cnt <= cnt - `MD_CNT_W'(1);
					if (cnt == `MD_CNT_W'(1)) begin
						state <= mulDivPkg::stFinish;
					end
				end
				default: begin
					state <= mulDivPkg::stIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			mulDivPkg::stIdle: begin
				if (start) begin
					mcand <= req.a;
					prod <= {{`MD_XLEN{1'b0}}, req.b};
					isSigned <= req.op == mulDivPkg::opMul;
				end
			end
			mulDivPkg::stLoad: begin
				if (isSigned && mcand[`MD_XLEN-1]) begin
					mcand <= -mcand;
				end
				if (isSigned && prod[`MD_XLEN-1]) begin
					prod[`MD_XLEN-1:0] <= -prod[`MD_XLEN-1:0];
				end
				neg <= isSigned && (mcand[`MD_XLEN-1] ^ prod[`MD_XLEN-1]);
			end
			mulDivPkg::stRun: begin
				// Add then shift right, carry lands in the top bit
				prod <= {sum, prod[`MD_XLEN-1:1]};
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		product = neg ? -prod : prod;
		res.done = state == mulDivPkg::stFinish;
		res.res0 = product[`MD_XLEN-1:0];
		res.res1 = product[2*`MD_XLEN-1:`MD_XLEN];
		res.divByZero = 1'b0;
	end

endmodule

`default_nettype wire

// ==== src/seqDivider.sv ====
// Sequential radix-2 restoring divider, one quotient bit per cycle
// Signed or unsigned operands, divide-by-zero detection
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_defines.svh"

module seqDivider (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire mulDivPkg::mdReqS req,
	output mulDivPkg::unitResS res
);

	mulDivPkg::unitStateE state;
	logic [`MD_CNT_W-1:0] cnt;

	// Dividend shifts out of q while quotient bits shift in
	logic [`MD_XLEN-1:0] q;
	logic [`MD_XLEN-1:0] r;
	logic [`MD_XLEN-1:0] bMag;
	logic isSigned;
	// Quotient sign, remainder follows the dividend
	logic qNeg;
	logic rNeg;
	logic divByZero;

	// One restoring step
	logic [`MD_XLEN:0] rShift;
	logic [`MD_XLEN-1:0] rSub;
	logic fits;

	always_comb begin
		rShift = {r, q[`MD_XLEN-1]};
		fits = rShift >= {1'b0, bMag};
		// Difference is below bMag when it fits, so 64 bits hold it
		rSub = rShift[`MD_XLEN-1:0] - bMag;
	end

	// ========================================================================
	// Sequencer
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mulDivPkg::stIdle;
			cnt <= '0;
		end else begin
			case (state)
				mulDivPkg::stIdle: begin
					if (start) begin
						state <= mulDivPkg::stLoad;
					end
				end
				mulDivPkg::stLoad: begin
					state <= mulDivPkg::stRun;
					cnt <= `MD_CNT_W'(`MD_ITER);
				end
				mulDivPkg::stRun: begin
					cnt <= cnt - `MD_CNT_W'(1);
					// Last quotient bit this cycle
					if (cnt == `MD_CNT_W'(1)) begin
						state <= mulDivPkg::stFinish;
					end
				end
				default: begin
					state <= mulDivPkg::stIdle;
				end
			endcase
		end
	end

	// ========================================================================
	// Datapath
	// ========================================================================

	always_ff @(posedge clk) begin
		case (state)
			mulDivPkg::stIdle: begin
				// Capture raw operands
				if (start) begin
					q <= req.a;
					bMag <= req.b;
					isSigned <= req.op == mulDivPkg::opDiv;
				end
			end
			mulDivPkg::stLoad: begin
				// Magnitudes in place
				if (isSigned && q[`MD_XLEN-1]) begin
					q <= -q;
				end
				if (isSigned && bMag[`MD_XLEN-1]) begin
					bMag <= -bMag;
				end
				qNeg <= isSigned && (q[`MD_XLEN-1] ^ bMag[`MD_XLEN-1]);
				rNeg <= isSigned && q[`MD_XLEN-1];
				divByZero <= bMag == '0;
				r <= '0;
			end
			mulDivPkg::stRun: begin
				q <= {q[`MD_XLEN-2:0], fits};
				r <= fits ? rSub : rShift[`MD_XLEN-1:0];
			end
			default: begin
			end
		endcase
	end

	// Signs applied on the way out, valid while done is high
	always_comb begin
		res.done = state == mulDivPkg::stFinish;
		// Zero divisor gives all ones, remainder is then the dividend
		res.res0 = divByZero ? '1 : (qNeg ? -q : q);
		res.res1 = rNeg ? -r : r;
		res.divByZero = divByZero;
	end

endmodule

`default_nettype wire

// ==== src/mulDivPkg.sv ====
// Shared types of the multiply/divide coprocessor
// Opcodes, unit states, command and result records, AXI4-Lite channels
`default_nettype none
`include "mulDiv_defines.svh"

package mulDivPkg;

	// Opcode, bit 1 selects the divider
	typedef enum logic [1:0] {
		opMul,
		opMulU,
		opDiv,
		opDivU
	} mdOpE;

	// Sequence followed by both arithmetic units
	typedef enum logic [1:0] {
		stIdle,
		stLoad,
		stRun,
		stFinish
	} unitStateE;

	// One command as handed to a unit
	typedef struct packed {
		mdOpE op;
		logic [`MD_XLEN-1:0] a;
		logic [`MD_XLEN-1:0] b;
	} mdReqS;

	// Output of one unit, res0 is quotient or low product
	typedef struct packed {
		logic done;
		logic [`MD_XLEN-1:0] res0;
		logic [`MD_XLEN-1:0] res1;
		logic divByZero;
	} unitResS;

	typedef struct packed {
		logic busy;
		logic done;
		logic divByZero;
		mdOpE lastOp;
	} mdStatusS;

	// ========================================================================
	// AXI4-Lite channels
	// ========================================================================

	// Master to slave
	typedef struct packed {
		logic [`MD_AXI_AW-1:0] awaddr;
		logic awvalid;
		logic [`MD_AXI_DW-1:0] wdata;
		logic [`MD_AXI_DW/8-1:0] wstrb;
		logic wvalid;
		logic bready;
		logic [`MD_AXI_AW-1:0] araddr;
		logic arvalid;
		logic rready;
	} axiLiteReqS;

	// Slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [`MD_AXI_DW-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiLiteRespS;

endpackage

`default_nettype wire

// ==== include/mulDiv_defines.svh ====
// Sizes and AXI4-Lite register map of the multiply/divide coprocessor
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// Operand width and iterations per operation, one bit each
`define MD_XLEN 64
`define MD_ITER 64
// Counter width that holds MD_ITER
`define MD_CNT_W 7

// AXI4-Lite bus widths
`define MD_AXI_AW 8
`define MD_AXI_DW 32
// Response codes
`define MD_AXI_OKAY 2'b00
`define MD_AXI_SLVERR 2'b10

// Register offsets
`define MD_REG_ALO 8'h00
`define MD_REG_AHI 8'h04
`define MD_REG_BLO 8'h08
`define MD_REG_BHI 8'h0C
`define MD_REG_CMD 8'h10
`define MD_REG_STATUS 8'h14
`define MD_REG_R0LO 8'h18
`define MD_REG_R0HI 8'h1C
`define MD_REG_R1LO 8'h20
`define MD_REG_R1HI 8'h24

`endif
